//--- hdl/ram_pkg.sv
package ram_pkg;

    // Default geometry of the banked memory
    localparam int DEF_WIDTH     = 32;
    localparam int DEF_DEPTH     = 40;       // Not a multiple of the bank size
    localparam int DEF_BANK_SIZE = 16;
    localparam int DEF_RD_PORTS  = 2;

    localparam logic [31:0] DEF_CLEAR_VALUE = 32'hA5A5_A5A5;   // Fill pattern after reset

    // One write-enable bit covers this many data bits
    localparam int BYTE_BITS = 8;

    // Post-reset clear sequencer
    typedef enum logic {
        CLEAR_RUN,                           // Walking rows, requests ignored
        CLEAR_DONE                           // All rows filled
    } clear_state_t;

endpackage

//--- hdl/ram_clear_seq.sv
`timescale 1ns/100ps

module ram_clear_seq #(
    parameter int BANK_SIZE = ram_pkg::DEF_BANK_SIZE,
    localparam int ROW_W    = $clog2(BANK_SIZE)
)(
    input  logic             clk,
    input  logic             rst,
    output logic             clearing,
    output logic [ROW_W-1:0] clear_row,
    output logic             ready
);
    import ram_pkg::*;

    clear_state_t state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= CLEAR_RUN;
            clear_row <= '0;
            ready     <= 1'b0;
        end else begin
            ready <= (state == CLEAR_DONE);      // One cycle behind the state
            if (state == CLEAR_RUN) begin
                if (clear_row == ROW_W'(BANK_SIZE - 1)) begin
                    state <= CLEAR_DONE;
                end else begin
                    clear_row <= clear_row + 1'b1;
                end
            end
        end
    end

    // All banks share the row, so BANK_SIZE clocks cover every row
    assign clearing = (state == CLEAR_RUN);

endmodule

//--- hdl/bank_decode.sv
`timescale 1ns/100ps

module bank_decode #(
    parameter int WIDTH                 = ram_pkg::DEF_WIDTH,
    parameter int DEPTH                 = ram_pkg::DEF_DEPTH,
    parameter int BANK_SIZE             = ram_pkg::DEF_BANK_SIZE,
    parameter int RD_PORTS              = ram_pkg::DEF_RD_PORTS,
    parameter logic [WIDTH-1:0] CLEAR_VALUE = WIDTH'(ram_pkg::DEF_CLEAR_VALUE),
    localparam int ADDR_W               = $clog2(DEPTH),
    localparam int ROW_W                = $clog2(BANK_SIZE),
    localparam int NUM_BANKS            = (DEPTH + BANK_SIZE - 1) / BANK_SIZE,
    localparam int BANK_W               = $clog2(NUM_BANKS > 1 ? NUM_BANKS : 2),
    localparam int BYTES                = WIDTH / ram_pkg::BYTE_BITS
)(
    input  logic                               ready,
    input  logic                               clearing,
    input  logic [ROW_W-1:0]                   clear_row,
    input  logic                               wr_valid,
    input  logic [ADDR_W-1:0]                  wr_addr,
    input  logic [BYTES-1:0]                   wr_be,
    input  logic [WIDTH-1:0]                   wr_data,
    input  logic [RD_PORTS-1:0]                rd_valid,
    input  logic [RD_PORTS-1:0][ADDR_W-1:0]    rd_addr,
    output logic [NUM_BANKS-1:0][BYTES-1:0]    bank_we,
    output logic [ROW_W-1:0]                   wr_row,
    output logic [WIDTH-1:0]                   wr_word,
    output logic [NUM_BANKS-1:0][RD_PORTS-1:0] bank_rd_en,
    output logic [RD_PORTS-1:0][ROW_W-1:0]     rd_row,
    output logic [RD_PORTS-1:0]                rd_accept,
    output logic [RD_PORTS-1:0][BANK_W-1:0]    rd_bank,
    output logic [RD_PORTS-1:0]                rd_in_range
);
    import ram_pkg::*;

    localparam int REMAIN = DEPTH % BANK_SIZE;

    logic              wr_accept;
    logic [BANK_W-1:0] wr_bank;

    assign wr_bank   = BANK_W'(wr_addr / BANK_SIZE);
    assign wr_accept = wr_valid && ready && (wr_addr < DEPTH);   // Out of range is dropped

    // Clear sequence owns the write port until done
    assign wr_row  = clearing ? clear_row : ROW_W'(wr_addr % BANK_SIZE);
    assign wr_word = clearing ? CLEAR_VALUE : wr_data;

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_we
        localparam int ROWS = (b == NUM_BANKS - 1 && REMAIN != 0) ? REMAIN : BANK_SIZE;

        // Short bank skips clear rows it does not have
        assign bank_we[b] = clearing ? {BYTES{clear_row < ROWS}}
                          : ((wr_accept && wr_bank == BANK_W'(b)) ? wr_be : '0);
    end

    for (genvar p = 0; p < RD_PORTS; p++) begin : g_rd
        assign rd_accept[p]   = rd_valid[p] && ready;
        assign rd_in_range[p] = rd_addr[p] < DEPTH;
        assign rd_bank[p]     = BANK_W'(rd_addr[p] / BANK_SIZE);
        assign rd_row[p]      = ROW_W'(rd_addr[p] % BANK_SIZE);

        for (genvar b = 0; b < NUM_BANKS; b++) begin : g_en
            assign bank_rd_en[b][p] = rd_accept[p] && rd_in_range[p]
                                   && (rd_bank[p] == BANK_W'(b));
        end
    end

endmodule

//--- hdl/ram_bank.sv
`timescale 1ns/100ps

module ram_bank #(
    parameter int WIDTH    = ram_pkg::DEF_WIDTH,
    parameter int ROWS     = ram_pkg::DEF_BANK_SIZE,
    parameter int RD_PORTS = ram_pkg::DEF_RD_PORTS,
    localparam int RW      = $clog2(ROWS > 1 ? ROWS : 2)
)(
    input  logic                                clk,
    input  logic [WIDTH/ram_pkg::BYTE_BITS-1:0] we,
    input  logic [RW-1:0]                       wr_row,
    input  logic [WIDTH-1:0]                    wr_word,
    input  logic [RD_PORTS-1:0]                 rd_en,
    input  logic [RD_PORTS-1:0][RW-1:0]         rd_row,
    output logic [RD_PORTS-1:0][WIDTH-1:0]      rdata
);
    import ram_pkg::*;

    localparam int BYTES = WIDTH / BYTE_BITS;

    logic [BYTES-1:0][BYTE_BITS-1:0] mem [ROWS];

    // Byte-lane masked write
    always_ff @(posedge clk) begin
        for (int j = 0; j < BYTES; j++) begin
            if (we[j]) begin
                mem[wr_row][j] <= wr_word[j*BYTE_BITS +: BYTE_BITS];
            end
        end
    end

    // Same-edge write is not visible here, so reads return the old word
    always_ff @(posedge clk) begin
        for (int p = 0; p < RD_PORTS; p++) begin
            if (rd_en[p]) begin
                rdata[p] <= mem[rd_row[p]];      // Hold when not addressed
            end
        end
    end

endmodule

//--- hdl/read_select.sv
`timescale 1ns/100ps

module read_select #(
    parameter int WIDTH     = ram_pkg::DEF_WIDTH,
    parameter int DEPTH     = ram_pkg::DEF_DEPTH,
    parameter int BANK_SIZE = ram_pkg::DEF_BANK_SIZE,
    parameter int RD_PORTS  = ram_pkg::DEF_RD_PORTS,
    localparam int NUM_BANKS = (DEPTH + BANK_SIZE - 1) / BANK_SIZE,
    localparam int BANK_W    = $clog2(NUM_BANKS > 1 ? NUM_BANKS : 2)
)(
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic [RD_PORTS-1:0]                           rd_accept,
    input  logic [RD_PORTS-1:0][BANK_W-1:0]               rd_bank,
    input  logic [RD_PORTS-1:0]                           rd_in_range,
    input  logic [NUM_BANKS-1:0][RD_PORTS-1:0][WIDTH-1:0] bank_rdata,
    output logic [RD_PORTS-1:0]                           rd_resp_valid,
    output logic [RD_PORTS-1:0][WIDTH-1:0]                rd_data
);
    logic [RD_PORTS-1:0][BANK_W-1:0] bank_q;
    logic [RD_PORTS-1:0]             range_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_resp_valid <= '0;
        end else begin
            rd_resp_valid <= rd_accept;          // No stall, fixed one cycle
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < RD_PORTS; p++) begin
            if (rd_accept[p]) begin
                bank_q[p]  <= rd_bank[p];
                range_q[p] <= rd_in_range[p];
            end
        end
    end

    // Banks already hold the registered word, only the mux is left
    always_comb begin
        for (int p = 0; p < RD_PORTS; p++) begin
            rd_data[p] = range_q[p] ? bank_rdata[bank_q[p]][p] : '0;
        end
    end

endmodule

//--- hdl/ram_top.sv
`timescale 1ns/100ps

module ram_top #(
    parameter int WIDTH                 = ram_pkg::DEF_WIDTH,
    parameter int DEPTH                 = ram_pkg::DEF_DEPTH,
    parameter int BANK_SIZE             = ram_pkg::DEF_BANK_SIZE,
    parameter int RD_PORTS              = ram_pkg::DEF_RD_PORTS,
    parameter logic [WIDTH-1:0] CLEAR_VALUE = WIDTH'(ram_pkg::DEF_CLEAR_VALUE),
    localparam int ADDR_W               = $clog2(DEPTH),
    localparam int BYTES                = WIDTH / ram_pkg::BYTE_BITS
)(
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             wr_valid,
    input  logic [ADDR_W-1:0]                wr_addr,
    input  logic [BYTES-1:0]                 wr_be,
    input  logic [WIDTH-1:0]                 wr_data,
    input  logic [RD_PORTS-1:0]              rd_valid,
    input  logic [RD_PORTS-1:0][ADDR_W-1:0]  rd_addr,
    output logic                             ready,
    output logic [RD_PORTS-1:0]              rd_resp_valid,
    output logic [RD_PORTS-1:0][WIDTH-1:0]   rd_data
);
    localparam int ROW_W     = $clog2(BANK_SIZE);
    localparam int NUM_BANKS = (DEPTH + BANK_SIZE - 1) / BANK_SIZE;
    localparam int REMAIN    = DEPTH % BANK_SIZE;
    localparam int BANK_W    = $clog2(NUM_BANKS > 1 ? NUM_BANKS : 2);

    logic                                          clearing;
    logic [ROW_W-1:0]                              clear_row;
    logic [NUM_BANKS-1:0][BYTES-1:0]               bank_we;
    logic [ROW_W-1:0]                              wr_row;
    logic [WIDTH-1:0]                              wr_word;
    logic [NUM_BANKS-1:0][RD_PORTS-1:0]            bank_rd_en;
    logic [RD_PORTS-1:0][ROW_W-1:0]                rd_row;
    logic [RD_PORTS-1:0]                           rd_accept;
    logic [RD_PORTS-1:0][BANK_W-1:0]               rd_bank;
    logic [RD_PORTS-1:0]                           rd_in_range;
    logic [NUM_BANKS-1:0][RD_PORTS-1:0][WIDTH-1:0] bank_rdata;

    ram_clear_seq #(
        .BANK_SIZE (BANK_SIZE)
    ) u_clear_seq (
        .clk       (clk),
        .rst       (rst),
        .clearing  (clearing),
        .clear_row (clear_row),
        .ready     (ready)
    );

    bank_decode #(
        .WIDTH       (WIDTH),
        .DEPTH       (DEPTH),
        .BANK_SIZE   (BANK_SIZE),
        .RD_PORTS    (RD_PORTS),
        .CLEAR_VALUE (CLEAR_VALUE)
    ) u_decode (
        .ready       (ready),
        .clearing    (clearing),
        .clear_row   (clear_row),
        .wr_valid    (wr_valid),
        .wr_addr     (wr_addr),
        .wr_be       (wr_be),
        .wr_data     (wr_data),
        .rd_valid    (rd_valid),
        .rd_addr     (rd_addr),
        .bank_we     (bank_we),
        .wr_row      (wr_row),
        .wr_word     (wr_word),
        .bank_rd_en  (bank_rd_en),
        .rd_row      (rd_row),
        .rd_accept   (rd_accept),
        .rd_bank     (rd_bank),
        .rd_in_range (rd_in_range)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        // Last bank takes the leftover rows
        localparam int ROWS = (b == NUM_BANKS - 1 && REMAIN != 0) ? REMAIN : BANK_SIZE;
        localparam int RW   = $clog2(ROWS > 1 ? ROWS : 2);

        logic [RD_PORTS-1:0][RW-1:0] bank_rd_row;

        for (genvar p = 0; p < RD_PORTS; p++) begin : g_row
            assign bank_rd_row[p] = rd_row[p][RW-1:0];
        end

        ram_bank #(
            .WIDTH    (WIDTH),
            .ROWS     (ROWS),
            .RD_PORTS (RD_PORTS)
        ) u_bank (
            .clk     (clk),
            .we      (bank_we[b]),
            .wr_row  (wr_row[RW-1:0]),
            .wr_word (wr_word),
            .rd_en   (bank_rd_en[b]),
            .rd_row  (bank_rd_row),
            .rdata   (bank_rdata[b])
        );
    end

    read_select #(
        .WIDTH     (WIDTH),
        .DEPTH     (DEPTH),
        .BANK_SIZE (BANK_SIZE),
        .RD_PORTS  (RD_PORTS)
    ) u_select (
        .clk           (clk),
        .rst           (rst),
        .rd_accept     (rd_accept),
        .rd_bank       (rd_bank),
        .rd_in_range   (rd_in_range),
        .bank_rdata    (bank_rdata),
        .rd_resp_valid (rd_resp_valid),
        .rd_data       (rd_data)
    );

endmodule

//--- tests/ram_props.sv
`timescale 1ns/100ps

module ram_props #(
    parameter int RD_PORTS = ram_pkg::DEF_RD_PORTS
)(
    input logic                clk,
    input logic                rst,
    input logic                ready,
    input logic                clearing,
    input logic [RD_PORTS-1:0] rd_accept,
    input logic [RD_PORTS-1:0] rd_resp_valid
);

    a_ready_low_in_clear: assert property (
        @(posedge clk) disable iff (rst) clearing |-> !ready
    ) else $error("ready is high while the clear is still running");

    // Ready follows the end of the clear by one cycle
    a_ready_after_clear: assert property (
        @(posedge clk) disable iff (rst) $fell(clearing) |=> ready
    ) else $error("ready did not rise one cycle after the clear ended");

    for (genvar p = 0; p < RD_PORTS; p++) begin : g_port
        a_resp_latency: assert property (
            @(posedge clk) disable iff (rst) rd_accept[p] |=> rd_resp_valid[p]
        ) else $error("read accepted on port %0d gave no response one cycle later", p);
    end

    a_no_resp_unready: assert property (
        @(posedge clk) !ready |-> (rd_resp_valid == '0)
    ) else $error("response valid while ready is low");

endmodule

bind ram_top ram_props #(
    .RD_PORTS (RD_PORTS)
) u_props (
    .clk           (clk),
    .rst           (rst),
    .ready         (ready),
    .clearing      (clearing),
    .rd_accept     (rd_accept),
    .rd_resp_valid (rd_resp_valid)
);

//--- tests/ram_tb.sv
`timescale 1ns/100ps

module ram_tb;
    import ram_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 4;
    localparam int ADDR_W       = $clog2(DEF_DEPTH);
    localparam int BYTES        = DEF_WIDTH / BYTE_BITS;
    localparam int MAX_VEC      = 256;

    // Operation codes of the vector file
    localparam int OP_IDLE  = 0;
    localparam int OP_WRITE = 1;
    localparam int OP_READ  = 2;
    localparam int OP_PAIR  = 3;                 // Same cycle as the line before
    localparam int OP_RESET = 4;

    logic                                  clk;
    logic                                  rst;
    logic                                  wr_valid;
    logic [ADDR_W-1:0]                     wr_addr;
    logic [BYTES-1:0]                      wr_be;
    logic [DEF_WIDTH-1:0]                  wr_data;
    logic [DEF_RD_PORTS-1:0]               rd_valid;
    logic [DEF_RD_PORTS-1:0][ADDR_W-1:0]   rd_addr;
    logic                                  ready;
    logic [DEF_RD_PORTS-1:0]               rd_resp_valid;
    logic [DEF_RD_PORTS-1:0][DEF_WIDTH-1:0] rd_data;

    logic [31:0] vec_op   [MAX_VEC];
    logic [31:0] vec_port [MAX_VEC];
    logic [31:0] vec_addr [MAX_VEC];
    logic [31:0] vec_be   [MAX_VEC];
    logic [31:0] vec_data [MAX_VEC];
    int          n_vec;
    int          watchdog_ns;
    logic        watchdog_armed;

    logic [DEF_RD_PORTS-1:0]                exp_pend;   // Response due at next falling edge
    logic [DEF_RD_PORTS-1:0][DEF_WIDTH-1:0] exp_data;

    ram_top u_ram_top (
        .clk           (clk),
        .rst           (rst),
        .wr_valid      (wr_valid),
        .wr_addr       (wr_addr),
        .wr_be         (wr_be),
        .wr_data       (wr_data),
        .rd_valid      (rd_valid),
        .rd_addr       (rd_addr),
        .ready         (ready),
        .rd_resp_valid (rd_resp_valid),
        .rd_data       (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: %s is %h, expected %h", name, actual, expected);
            $display("Verification failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic idle_inputs();
        wr_valid = 1'b0;
        wr_addr  = '0;
        wr_be    = '0;
        wr_data  = '0;
        rd_valid = '0;
        rd_addr  = '0;
    endtask

    task automatic load_vectors();
        int fd;
        int got;
        logic [31:0] f_op, f_port, f_addr, f_be, f_data;
        n_vec = 0;
        fd = $fopen("tests/ram_vectors.txt", "r");
        if (fd == 0) begin
            $display("The vector file tests/ram_vectors.txt could not be opened");
            $display("Verification failed");
            $fatal(1, "no vector file");
        end else begin
            got = $fscanf(fd, "%h %h %h %h %h\n", f_op, f_port, f_addr, f_be, f_data);
            while (got == 5 && n_vec < MAX_VEC) begin
                vec_op[n_vec]   = f_op;
                vec_port[n_vec] = f_port;
                vec_addr[n_vec] = f_addr;
                vec_be[n_vec]   = f_be;
                vec_data[n_vec] = f_data;
                n_vec++;
                got = $fscanf(fd, "%h %h %h %h %h\n", f_op, f_port, f_addr, f_be, f_data);
            end
            $fclose(fd);
        end
    endtask

    // Compare the responses of reads accepted at the last rising edge
    task automatic check_responses();
        for (int p = 0; p < DEF_RD_PORTS; p++) begin
            check_value($sformatf("rd_resp_valid[%0d]", p), 32'(rd_resp_valid[p]),
                        32'(exp_pend[p]));
            if (exp_pend[p]) begin
                check_value($sformatf("rd_data[%0d]", p), rd_data[p], exp_data[p]);
            end
            exp_pend[p] = 1'b0;
        end
    endtask

    task automatic apply_op(input int i);
        int port;
        port = int'(vec_port[i]);
        case (int'(vec_op[i]))
            OP_IDLE: ;
            OP_WRITE: begin
                wr_valid = 1'b1;
                wr_addr  = vec_addr[i][ADDR_W-1:0];
                wr_be    = vec_be[i][BYTES-1:0];
                wr_data  = vec_data[i];
            end
            OP_READ, OP_PAIR: begin
                if (port >= DEF_RD_PORTS) begin
                    $display("Vector line %0d names read port %0d, which does not exist",
                             i + 1, port);
                    $display("Verification failed");
                    $fatal(1, "bad port in vector file");
                end else begin
                    rd_valid[port] = 1'b1;
                    rd_addr[port]  = vec_addr[i][ADDR_W-1:0];
                    exp_pend[port] = 1'b1;
                    exp_data[port] = vec_data[i];
                end
            end
            default: begin
                $display("Vector line %0d holds unknown operation %0h", i + 1, vec_op[i]);
                $display("Verification failed");
                $fatal(1, "bad operation in vector file");
            end
        endcase
    endtask

    // Requests stay asserted through the clear and must be ignored
    task automatic run_reset();
        idle_inputs();
        rst      = 1'b1;
        wr_valid = 1'b1;
        wr_addr  = ADDR_W'(3);
        wr_be    = '1;
        wr_data  = '0;
        rd_valid = '1;
        #1;
        check_value("ready", 32'(ready), 32'h0);
        check_value("rd_resp_valid", 32'(rd_resp_valid), 32'h0);
        exp_pend = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        while (!ready) begin
            check_value("rd_resp_valid", 32'(rd_resp_valid), 32'h0);
            @(negedge clk);
        end
        idle_inputs();
    endtask

    initial begin
        int i;
        int n_resets;
        rst            = 1'b0;
        watchdog_armed = 1'b0;
        exp_pend       = '0;
        exp_data       = '0;
        idle_inputs();
        load_vectors();
        if (n_vec == 0) begin
            $display("The vector file holds no operations");
            $display("Verification failed");
            $fatal(1, "empty vector file");
        end
        n_resets = 1;
        for (int k = 0; k < n_vec; k++) begin
            if (int'(vec_op[k]) == OP_RESET) n_resets++;
        end
        watchdog_ns = (n_vec + n_resets * (DEF_BANK_SIZE + RESET_CYCLES + 4))
                      * 2 * CLK_PERIOD;
        watchdog_armed = 1'b1;

        @(negedge clk);
        run_reset();
        i = 0;
        while (i < n_vec) begin
            @(negedge clk);
            check_responses();
            idle_inputs();
            if (int'(vec_op[i]) == OP_RESET) begin
                run_reset();
                i++;
            end else begin
                apply_op(i);
                i++;
                while (i < n_vec && int'(vec_op[i]) == OP_PAIR) begin
                    apply_op(i);
                    i++;
                end
            end
        end
        repeat (2) begin
            @(negedge clk);
            check_responses();
            idle_inputs();
        end
        $display("Verification passed");
        $finish;
    end

    initial begin
        wait (watchdog_armed);
        #(watchdog_ns);
        $display("Timeout: the vectors did not finish within %0d ns", watchdog_ns);
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- tests/ram_vectors.txt
2 0 00 0 A5A5A5A5
3 1 0F 0 A5A5A5A5
2 0 10 0 A5A5A5A5
3 1 1F 0 A5A5A5A5
2 0 20 0 A5A5A5A5
3 1 27 0 A5A5A5A5
2 1 23 0 A5A5A5A5
0 0 00 0 00000000
1 0 03 F 11223344
1 0 12 F 55667788
1 0 25 F 99AABBCC
1 0 27 F DEADBEEF
2 0 03 0 11223344
3 1 12 0 55667788
2 0 25 0 99AABBCC
3 1 27 0 DEADBEEF
2 1 03 0 11223344
2 1 25 0 99AABBCC
1 0 08 F CAFEF00D
2 0 08 0 CAFEF00D
1 0 03 1 000000AA
2 0 03 0 112233AA
1 0 03 6 00BBCC00
2 1 03 0 11BBCCAA
1 0 21 8 77000000
2 0 21 0 77A5A5A5
1 0 12 0 FFFFFFFF
2 1 12 0 55667788
1 0 05 F 0BADC0DE
3 0 05 0 A5A5A5A5
2 0 05 0 0BADC0DE
1 0 27 F 12345678
3 1 27 0 DEADBEEF
2 1 27 0 12345678
0 0 00 0 00000000
1 0 28 F FFFFFFFF
1 0 38 F 01010101
1 0 3F F 02020202
2 0 28 0 00000000
3 1 3F 0 00000000
2 0 08 0 CAFEF00D
3 1 18 0 A5A5A5A5
2 0 20 0 A5A5A5A5
3 1 27 0 12345678
2 0 03 0 11BBCCAA
4 0 00 0 00000000
2 0 03 0 A5A5A5A5
3 1 08 0 A5A5A5A5
2 0 12 0 A5A5A5A5
3 1 21 0 A5A5A5A5
2 0 27 0 A5A5A5A5
3 1 05 0 A5A5A5A5
1 0 10 F 600DF00D
2 1 10 0 600DF00D
0 0 00 0 00000000

//--- sources.f
hdl/ram_pkg.sv
hdl/ram_clear_seq.sv
hdl/bank_decode.sv
hdl/ram_bank.sv
hdl/read_select.sv
hdl/ram_top.sv
tests/ram_props.sv
tests/ram_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the banked memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module ram_tb -f sources.f -o ram_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/ram_sim 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Verification passed"; then
    exit 0
else
    echo "Pass message not found in the simulation output"
    exit 1
fi
